// ==== hdl/cpu_pkg.sv ====
// Opcodes, register indices and bus structs shared by the CPU blocks; import into each module
`default_nettype none

package cpu_pkg;

    // Data and address width of the whole machine
    localparam int WORD_WIDTH = 16;

    // Special register indices
    localparam logic [3:0] wr_id = 4'd0;
    localparam logic [3:0] pc_id = 4'd1;
    localparam logic [3:0] sp_id = 4'd2;
    localparam logic [3:0] sr_id = 4'd3;

    typedef enum logic [3:0] {
        op_set    = 4'h0,
        op_read   = 4'h1,
        op_cpy    = 4'h2,
        op_add    = 4'h3,
        op_sub    = 4'h4,
        op_and    = 4'h5,
        op_xor    = 4'h6,
        op_eq     = 4'h7,
        op_jif    = 4'h8,
        op_load   = 4'h9,
        op_str    = 4'ha,
        op_push   = 4'hb,
        op_pop    = 4'hc,
        op_debug  = 4'hd,
        op_retint = 4'he,
        op_quit   = 4'hf
    } opcode_t;

    // Instruction sits in the low byte of a memory word
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] arg;
    } instr_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [WORD_WIDTH-1:0] paddr;
        logic [WORD_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] prdata;
        logic                  pready;
    } apb_rsp_t;

    // Register file write request
    typedef struct packed {
        logic                  valid;
        logic [3:0]            index;
        logic [WORD_WIDTH-1:0] value;
    } reg_write_t;

endpackage

`default_nettype wire

// ==== hdl/cpu_alu.sv ====
// Combinational ALU of the CPU core that turns the current instruction into a register write
`default_nettype none

module cpu_alu
    import cpu_pkg::*;
(
    input  instr_t                instr,
    input  logic [WORD_WIDTH-1:0] working_register,
    input  logic [WORD_WIDTH-1:0] other_register,
    input  logic [WORD_WIDTH-1:0] status_register,
    output reg_write_t            alu_write
);

    always_comb
    begin
        alu_write.valid = 1'b1;
        alu_write.index = wr_id;
        alu_write.value = '0;
        case (instr.opcode)
            op_set:
                alu_write.value = WORD_WIDTH'(instr.arg);
            op_read:
                alu_write.value = other_register;
            op_cpy:
            begin
                // Only opcode that targets the argument register
                alu_write.index = instr.arg;
                alu_write.value = working_register;
            end
            op_add:
                alu_write.value = working_register + other_register;
            op_sub:
                alu_write.value = working_register - other_register;
            op_and:
                alu_write.value = working_register & other_register;
            op_xor:
                alu_write.value = working_register ^ other_register;
            op_eq:
                alu_write.value = (working_register == other_register) ? WORD_WIDTH'(1) : '0;
            default:
            begin
                // Memory, flow and control opcodes
                alu_write.valid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_mem_port.sv ====
// APB master of the CPU core, fetches each instruction and runs its data transfer if any
`default_nettype none

module cpu_mem_port
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  logic [WORD_WIDTH-1:0] program_counter,
    input  logic [WORD_WIDTH-1:0] stack_pointer,
    input  logic [WORD_WIDTH-1:0] working_register,
    input  logic [WORD_WIDTH-1:0] other_register,
    output apb_req_t              apb_req,
    input  apb_rsp_t              apb_rsp,
    output instr_t                instr,
    output reg_write_t            mem_write,
    output logic                  step_done
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch_setup,
        st_fetch_access,
        st_data_setup,
        st_data_access,
        st_done
    } state_t;

    state_t                state;
    instr_t                fetched;
    logic [WORD_WIDTH-1:0] read_data;
    logic [WORD_WIDTH-1:0] data_addr;
    logic                  in_data;

    function automatic logic is_mem_op(input opcode_t op);
        return op inside {op_load, op_str, op_push, op_pop};
    endfunction

    assign fetched = instr_t'(apb_rsp.prdata[7:0]);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= st_idle;
            instr <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (enable)
                        state <= st_fetch_setup;
                st_fetch_setup:
                    state <= st_fetch_access;
                st_fetch_access:
                    if (apb_rsp.pready)
                    begin
                        instr <= fetched;
                        state <= is_mem_op(fetched.opcode) ? st_data_setup : st_done;
                    end
                st_data_setup:
                    state <= st_data_access;
                st_data_access:
                    if (apb_rsp.pready)
                        state <= st_done;
                st_done:
                    // Next fetch right after step_done, none after quit
                    if (enable)
                        state <= (instr.opcode == op_quit) ? st_idle : st_fetch_setup;
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_data_access && apb_rsp.pready)
            read_data <= apb_rsp.prdata;
    end

    // Stack grows upwards, pop reads the word below sp
    always_comb
    begin
        case (instr.opcode)
            op_push: data_addr = stack_pointer;
            op_pop:  data_addr = stack_pointer - 1'b1;
            default: data_addr = other_register;
        endcase
    end

    assign in_data = (state == st_data_setup) || (state == st_data_access);

    // Registers only change on step_done, so these hold over a transfer
    always_comb
    begin
        apb_req.psel    = (state != st_idle) && (state != st_done);
        apb_req.penable = (state == st_fetch_access) || (state == st_data_access);
        apb_req.pwrite  = in_data && (instr.opcode inside {op_str, op_push});
        apb_req.paddr   = in_data ? data_addr : program_counter;
        apb_req.pwdata  = working_register;
    end

    assign step_done = (state == st_done) && enable;

    always_comb
    begin
        mem_write.valid = step_done && (instr.opcode inside {op_load, op_pop});
        mem_write.index = wr_id;
        mem_write.value = read_data;
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_interrupt.sv ====
// Interrupt controller of the CPU core, picks a request line and saves and restores pc
`default_nettype none

module cpu_interrupt
    import cpu_pkg::*;
#(
    parameter logic [WORD_WIDTH-1:0] INT_VECTOR_BASE = 16'h0040
)(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [3:0]            interrupt_request,
    input  logic [3:0]            int_mask,
    input  instr_t                instr,
    input  logic                  step_done,
    input  logic [WORD_WIDTH-1:0] next_pc,
    output logic                  take,
    output logic [WORD_WIDTH-1:0] vector
);

    logic                  in_context;
    logic [WORD_WIDTH-1:0] saved_pc;
    logic [3:0]            pending;
    logic [1:0]            line;
    logic                  enter_now;
    logic                  retint_now;

    assign pending = interrupt_request & int_mask;

    // Lowest index has priority
    always_comb
    begin
        if (pending[0])
            line = 2'd0;
        else if (pending[1])
            line = 2'd1;
        else if (pending[2])
            line = 2'd2;
        else
            line = 2'd3;
    end

    // No nesting, requests wait until retint
    assign enter_now  = step_done && !in_context && (|pending);
    assign retint_now = step_done && in_context && (instr.opcode == op_retint);

    assign take   = enter_now || retint_now;
    assign vector = retint_now ? saved_pc
                               : INT_VECTOR_BASE + WORD_WIDTH'({line, 2'b00});

    always_ff @(posedge clk)
    begin
        if (!reset)
            in_context <= 1'b0;
        else if (enter_now)
            in_context <= 1'b1;
        else if (retint_now)
            in_context <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (enter_now)
            saved_pc <= next_pc;
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_core.sv ====
// Top level of the accumulator CPU, holds the register file and ties the ALU, APB and interrupts
`default_nettype none

module cpu_core
    import cpu_pkg::*;
#(
    parameter logic [WORD_WIDTH-1:0] RESET_PC        = 16'h0000,
    parameter logic [WORD_WIDTH-1:0] INT_VECTOR_BASE = 16'h0040,
    parameter logic [WORD_WIDTH-1:0] STACK_RESET     = 16'h0100
)(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    output apb_req_t              apb_req,
    input  apb_rsp_t              apb_rsp,
    input  logic [3:0]            interrupt_request,
    output logic                  quit,
    output logic                  debug,
    output logic [WORD_WIDTH-1:0] debug_wr
);

    logic [WORD_WIDTH-1:0] registers [16];
    logic [WORD_WIDTH-1:0] other_register;
    logic [WORD_WIDTH-1:0] next_pc;
    logic [WORD_WIDTH-1:0] vector;
    instr_t                instr;
    reg_write_t            alu_write;
    reg_write_t            mem_write;
    reg_write_t            reg_write;
    logic                  step_done;
    logic                  take;
    logic                  jump;
    logic                  port_enable;

    assign other_register = registers[instr.arg];
    assign port_enable    = enable && !quit;

    cpu_alu alu0 (
        .instr            (instr),
        .working_register (registers[wr_id]),
        .other_register   (other_register),
        .status_register  (registers[sr_id]),
        .alu_write        (alu_write)
    );

    cpu_mem_port mem_port0 (
        .clk              (clk),
        .reset            (reset),
        .enable           (port_enable),
        .program_counter  (registers[pc_id]),
        .stack_pointer    (registers[sp_id]),
        .working_register (registers[wr_id]),
        .other_register   (other_register),
        .apb_req          (apb_req),
        .apb_rsp          (apb_rsp),
        .instr            (instr),
        .mem_write        (mem_write),
        .step_done        (step_done)
    );

    cpu_interrupt #(
        .INT_VECTOR_BASE (INT_VECTOR_BASE)
    ) interrupt0 (
        .clk               (clk),
        .reset             (reset),
        .interrupt_request (interrupt_request),
        .int_mask          (registers[sr_id][3:0]),
        .instr             (instr),
        .step_done         (step_done),
        .next_pc           (next_pc),
        .take              (take),
        .vector            (vector)
    );

    // Memory result and ALU result never both valid
    assign reg_write = mem_write.valid ? mem_write : alu_write;
    assign jump      = (instr.opcode == op_jif) && (registers[wr_id] != '0);

    // pc that follows this instruction when no interrupt is taken
    always_comb
    begin
        if (jump)
            next_pc = other_register;
        else if (reg_write.valid && reg_write.index == pc_id)
            next_pc = reg_write.value;
        else
            next_pc = registers[pc_id] + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < 16; i++)
                registers[i] <= '0;
            registers[pc_id] <= RESET_PC;
            registers[sp_id] <= STACK_RESET;
            quit <= 1'b0;
        end
        else if (step_done)
        begin
            if (reg_write.valid)
                registers[reg_write.index] <= reg_write.value;
            if (instr.opcode == op_push)
                registers[sp_id] <= registers[sp_id] + 1'b1;
            else if (instr.opcode == op_pop)
                registers[sp_id] <= registers[sp_id] - 1'b1;
            // Last so it wins over a direct write to pc
            registers[pc_id] <= take ? vector : next_pc;
            if (instr.opcode == op_quit)
                quit <= 1'b1;
        end
    end

    assign debug    = step_done && (instr.opcode == op_debug);
    assign debug_wr = registers[wr_id];

endmodule

`default_nettype wire

// ==== sim/apb_memory_model.sv ====
// APB slave memory for the CPU testbench, with random wait states and backdoor access
`default_nettype none

module apb_memory_model
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     max_wait,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic [WORD_WIDTH-1:0] mem [1024];
    logic [1:0]            wait_count;

    // Wait states are chosen in the setup cycle
    always @(posedge clk)
    begin
        if (!reset)
            wait_count <= 2'd0;
        else if (apb_req.psel && !apb_req.penable)
            wait_count <= max_wait ? 2'd3 : 2'($urandom % 4);
        else if (apb_req.psel && apb_req.penable && wait_count != 2'd0)
            wait_count <= wait_count - 2'd1;
    end

    assign apb_rsp.pready = apb_req.psel && apb_req.penable && (wait_count == 2'd0);
    assign apb_rsp.prdata = mem[apb_req.paddr[9:0]];

    always @(posedge clk)
    begin
        if (apb_req.psel && apb_req.penable && apb_req.pwrite && apb_rsp.pready)
            mem[apb_req.paddr[9:0]] = apb_req.pwdata;
    end

    function void write_word(input int addr, input logic [WORD_WIDTH-1:0] value);
        mem[addr] = value;
    endfunction

    function logic [WORD_WIDTH-1:0] read_word(input int addr);
        return mem[addr];
    endfunction

endmodule

`default_nettype wire

// ==== sim/cpu_assertions.sv ====
// APB and quit protocol checks, bound into the CPU core by the bind at the end
`default_nettype none

module cpu_assertions
    import cpu_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp,
    input logic     quit
);

    // Setup is always followed by an access with the same address
    setup_then_access: assert property (@(posedge clk) disable iff (!reset)
        apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable
            && $stable(apb_req.paddr))
        else $error("APB setup not followed by access");

    addr_stable: assert property (@(posedge clk) disable iff (!reset)
        apb_req.psel && apb_req.penable && !apb_rsp.pready |=> apb_req.penable
            && $stable(apb_req.paddr) && $stable(apb_req.pwrite))
        else $error("APB address changed before pready");

    quit_sticky: assert property (@(posedge clk) disable iff (!reset) quit |=> quit)
        else $error("quit deasserted");

    idle_after_reset: assert property (@(posedge clk) $rose(reset) |-> !apb_req.psel)
        else $error("psel set right after reset");

endmodule

bind cpu_core cpu_assertions assertions0 (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .quit    (quit)
);

`default_nettype wire

// ==== sim/cpu_tb.sv ====
// Testbench for the CPU core that runs small programs against an ISA reference
`default_nettype none

module cpu_tb
    import cpu_pkg::*;
;

    localparam logic [15:0] RESET_PC        = 16'h0000;
    localparam logic [15:0] INT_VECTOR_BASE = 16'h0040;
    localparam logic [15:0] STACK_RESET     = 16'h0100;
    localparam logic [15:0] MARKER_ADDR     = 16'd30;
    localparam logic [15:0] MASKED_ADDR     = 16'd31;

    logic        clk;
    logic        reset;
    logic        enable;
    logic        max_wait;
    logic [3:0]  interrupt_request;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        quit;
    logic        debug;
    logic [15:0] debug_wr;

    logic [15:0] image [1024];
    logic [15:0] ref_mem [1024];
    logic [15:0] ref_reg [16];
    logic [3:0]  ref_irq;
    logic        ref_in_ctx;
    logic [15:0] ref_saved;
    logic        ref_quit;
    logic [15:0] expected_q [$];
    int          check_count;
    int          marker_writes;
    int          masked_writes;

    cpu_core #(
        .RESET_PC        (RESET_PC),
        .INT_VECTOR_BASE (INT_VECTOR_BASE),
        .STACK_RESET     (STACK_RESET)
    ) dut0 (
        .clk               (clk),
        .reset             (reset),
        .enable            (enable),
        .apb_req           (apb_req),
        .apb_rsp           (apb_rsp),
        .interrupt_request (interrupt_request),
        .quit              (quit),
        .debug             (debug),
        .debug_wr          (debug_wr)
    );

    apb_memory_model mem0 (
        .clk      (clk),
        .reset    (reset),
        .max_wait (max_wait),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            $display("MISMATCH time=%0t %s actual=%h expected=%h", $time, name, actual,
                     expected);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // Executes one instruction on the reference copy of the machine
    function void isa_step();
        instr_t      ins;
        logic [15:0] wr;
        logic [15:0] arg_val;
        logic [15:0] next_pc;
        logic [3:0]  mask;
        logic [3:0]  pend;
        logic        was_ctx;
        int          line;
        ins     = instr_t'(ref_mem[ref_reg[1][9:0]][7:0]);
        wr      = ref_reg[0];
        arg_val = ref_reg[ins.arg];
        next_pc = ref_reg[1] + 16'd1;
        was_ctx = ref_in_ctx;
        // Mask as it stands before this instruction's own writes
        mask    = ref_reg[3][3:0];
        case (ins.opcode)
            op_set:   ref_reg[0] = {12'h000, ins.arg};
            op_read:  ref_reg[0] = arg_val;
            op_cpy:
            begin
                ref_reg[ins.arg] = wr;
                if (ins.arg == 4'd1)
                    next_pc = wr;
            end
            op_add:   ref_reg[0] = wr + arg_val;
            op_sub:   ref_reg[0] = wr - arg_val;
            op_and:   ref_reg[0] = wr & arg_val;
            op_xor:   ref_reg[0] = wr ^ arg_val;
            op_eq:    ref_reg[0] = (wr == arg_val) ? 16'd1 : 16'd0;
            op_jif:
                if (wr != 16'd0)
                    next_pc = arg_val;
            op_load:  ref_reg[0] = ref_mem[arg_val[9:0]];
            op_str:
            begin
                ref_mem[arg_val[9:0]] = wr;
                // Testbench drops line 2 when the handler marks
                if (arg_val == MARKER_ADDR)
                    ref_irq[2] = 1'b0;
            end
            op_push:
            begin
                ref_mem[ref_reg[2][9:0]] = wr;
                ref_reg[2] = ref_reg[2] + 16'd1;
            end
            op_pop:
            begin
                ref_reg[2] = ref_reg[2] - 16'd1;
                ref_reg[0] = ref_mem[ref_reg[2][9:0]];
            end
            op_debug: expected_q.push_back(wr);
            op_retint:
                if (was_ctx)
                begin
                    next_pc = ref_saved;
                    ref_in_ctx = 1'b0;
                end
            default:  ref_quit = 1'b1;
        endcase
        pend = ref_irq & mask;
        if (!was_ctx && pend != 4'd0)
        begin
            line = 0;
            for (int i = 3; i >= 0; i--)
                if (pend[i])
                    line = i;
            ref_saved  = next_pc;
            ref_in_ctx = 1'b1;
            next_pc    = INT_VECTOR_BASE + 16'(4 * line);
        end
        ref_reg[1] = next_pc;
    endfunction

    // Compare process for debug pulses
    always @(negedge clk)
    begin
        if (reset && debug)
        begin
            if (expected_q.size() == 0)
            begin
                $display("Unexpected debug pulse at time %0t", $time);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            else
                check_value("debug_wr", debug_wr, expected_q.pop_front());
        end
    end

    // Counts marker writes and releases line 2 once the handler has marked
    always @(negedge clk)
    begin
        if (reset && apb_req.psel && apb_req.penable && apb_req.pwrite && apb_rsp.pready)
        begin
            if (apb_req.paddr == MASKED_ADDR)
                masked_writes++;
            if (apb_req.paddr == MARKER_ADDR)
            begin
                marker_writes++;
                @(posedge clk);
                #10 interrupt_request[2] = 1'b0;
            end
        end
    end

    task automatic clear_image();
        for (int a = 0; a < 1024; a++)
            image[a] = 16'(a) * 16'h9e37 + 16'h1234;
    endtask

    task automatic put(input int addr, input opcode_t op, input logic [3:0] arg);
        image[addr] = {8'h00, op, arg};
    endtask

    task automatic wait_for_quit();
        int cycles;
        cycles = 0;
        while (!quit)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > 20000)
            begin
                $display("Timeout: the CPU never executed quit");
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
        end
    endtask

    task automatic run_program(input logic slow, input logic [3:0] lines);
        int steps;
        for (int a = 0; a < 1024; a++)
        begin
            ref_mem[a] = image[a];
            mem0.write_word(a, image[a]);
        end
        for (int r = 0; r < 16; r++)
            ref_reg[r] = 16'd0;
        ref_reg[1] = RESET_PC;
        ref_reg[2] = STACK_RESET;
        ref_irq    = lines;
        ref_in_ctx = 1'b0;
        ref_quit   = 1'b0;
        expected_q.delete();
        steps = 0;
        while (!ref_quit)
        begin
            isa_step();
            steps++;
            if (steps > 2000)
            begin
                $display("Reference model never reached quit");
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
        end
        @(posedge clk);
        #10;
        reset = 1'b0;
        enable = 1'b0;
        max_wait = slow;
        interrupt_request = lines;
        marker_writes = 0;
        masked_writes = 0;
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b1;
        enable = 1'b1;
        wait_for_quit();
        @(negedge clk);
        check_value("debug_pulses_left", 16'(expected_q.size()), 16'd0);
        for (int a = 0; a < 1024; a++)
            check_value($sformatf("mem[%0d]", a), mem0.read_word(a), ref_mem[a]);
    endtask

    task automatic build_arith();
        clear_image();
        put(0, op_set, 5);
        put(1, op_cpy, 4);
        put(2, op_set, 12);
        put(3, op_cpy, 5);
        put(4, op_add, 4);
        put(5, op_debug, 0);
        put(6, op_sub, 5);
        put(7, op_debug, 0);
        put(8, op_xor, 5);
        put(9, op_and, 4);
        put(10, op_debug, 0);
        put(11, op_eq, 4);
        put(12, op_debug, 0);
        put(13, op_set, 5);
        put(14, op_eq, 4);
        put(15, op_debug, 0);
        put(16, op_read, 5);
        put(17, op_add, 5);
        put(18, op_debug, 0);
        put(19, op_quit, 0);
    endtask

    task automatic build_stack();
        clear_image();
        put(0, op_set, 7);
        put(1, op_push, 0);
        put(2, op_set, 3);
        put(3, op_push, 0);
        put(4, op_set, 15);
        put(5, op_cpy, 4);
        put(6, op_add, 4);
        put(7, op_cpy, 4);
        put(8, op_set, 9);
        put(9, op_str, 4);
        put(10, op_pop, 0);
        put(11, op_debug, 0);
        put(12, op_pop, 0);
        put(13, op_debug, 0);
        put(14, op_load, 4);
        put(15, op_debug, 0);
        put(16, op_read, 2);
        put(17, op_debug, 0);
        put(18, op_quit, 0);
    endtask

    task automatic build_loop();
        clear_image();
        put(0, op_set, 3);
        put(1, op_cpy, 4);
        put(2, op_set, 1);
        put(3, op_cpy, 6);
        put(4, op_set, 6);
        put(5, op_cpy, 5);
        put(6, op_read, 4);
        put(7, op_debug, 0);
        put(8, op_sub, 6);
        put(9, op_cpy, 4);
        put(10, op_jif, 5);
        put(11, op_quit, 0);
    endtask

    task automatic build_interrupt();
        clear_image();
        put(0, op_set, 15);
        put(1, op_cpy, 6);
        put(2, op_add, 6);
        put(3, op_cpy, 6);
        put(4, op_set, 1);
        put(5, op_add, 6);
        put(6, op_cpy, 7);
        put(7, op_set, 15);
        put(8, op_cpy, 8);
        put(9, op_set, 13);
        put(10, op_cpy, 9);
        // Only line 2 unmasked
        put(11, op_set, 4);
        put(12, op_cpy, 3);
        put(13, op_load, 6);
        put(14, op_eq, 10);
        put(15, op_jif, 9);
        put(16, op_load, 6);
        put(17, op_debug, 0);
        put(18, op_load, 7);
        put(19, op_debug, 0);
        put(20, op_read, 2);
        put(21, op_debug, 0);
        put(22, op_quit, 0);
        image[30] = 16'd0;
        image[31] = 16'd0;
        // Line 1 handler that must never run
        put(16'h44, op_str, 7);
        put(16'h45, op_retint, 0);
        // Line 2 handler keeps wr on the stack
        put(16'h48, op_push, 0);
        put(16'h49, op_set, 5);
        put(16'h4a, op_str, 6);
        put(16'h4b, op_pop, 0);
        put(16'h4c, op_retint, 0);
    endtask

    initial
    begin
        void'($urandom(75));
        reset = 1'b0;
        enable = 1'b0;
        max_wait = 1'b0;
        interrupt_request = 4'd0;
        check_count = 0;
        build_arith();
        run_program(1'b0, 4'b0000);
        build_stack();
        run_program(1'b0, 4'b0000);
        build_loop();
        run_program(1'b0, 4'b0000);
        build_interrupt();
        run_program(1'b0, 4'b0110);
        check_value("marker_writes", 16'(marker_writes), 16'd1);
        check_value("masked_writes", 16'(masked_writes), 16'd0);
        build_stack();
        run_program(1'b1, 4'b0000);
        if (check_count > 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/cpu_pkg.sv
hdl/cpu_alu.sv
hdl/cpu_mem_port.sv
hdl/cpu_interrupt.sv
hdl/cpu_core.sv
sim/apb_memory_model.sv
sim/cpu_assertions.sv
sim/cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = cpu_tb
FILELIST  = src.f
PASS_TEXT = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench under Verilator"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
